/* ex_golden.hex */
// count first; per record: pc rs1_idx rs2_idx rs1 rs2 imm op1_pc op2_imm rd op br fun
// then mm_valid (0 for squash or bubble) mm_result mm_store_data redirect (0 for none) target
2a
00000100 01 02 00000005 00000003 00000000 0 0 03 1 0 0 1 00000008 00000003 0 00000000
00000104 04 05 00000003 00000005 00000000 0 0 06 1 0 1 1 fffffffe 00000005 0 00000000
00000108 07 08 00000001 00000024 00000000 0 0 09 1 0 2 1 00000010 00000024 0 00000000
0000010c 0a 0b ffffffff 00000001 00000000 0 0 0c 1 0 3 1 00000001 00000001 0 00000000
00000110 0d 0e ffffffff 00000001 00000000 0 0 0f 1 0 4 1 00000000 00000001 0 00000000
00000114 10 11 0000ff00 12345678 00000ff0 0 1 12 1 0 5 1 0000f0f0 12345678 0 00000000
00000118 13 14 80000000 00000004 00000000 0 0 15 1 0 6 1 08000000 00000004 0 00000000
0000011c 16 17 80000000 00000004 00000000 0 0 18 1 0 7 1 f8000000 00000004 0 00000000
00000120 19 1a 0f0f0000 000000f0 00000000 0 0 1b 1 0 8 1 0f0f00f0 000000f0 0 00000000
00000124 1c 1d ff00ff00 0ff00ff0 00000000 0 0 1e 1 0 9 1 0f000f00 0ff00ff0 0 00000000
00000128 00 1f 00000000 00000000 12345000 0 1 01 1 0 a 1 12345000 00000000 0 00000000
0000012c 00 00 00000000 00000000 00001000 1 1 02 1 0 0 1 0000112c 00000000 0 00000000
00000130 02 02 00000000 00000000 00000000 0 0 03 1 0 0 1 00002258 0000112c 0 00000000
00000134 05 03 00003000 00000000 00000000 0 0 04 1 0 1 1 00000da8 00002258 0 00000000
00000138 06 00 00001000 00000000 00000010 0 1 07 2 0 0 1 00001010 00000000 0 00000000
0000013c 07 00 00000055 00000000 00000001 0 1 08 1 0 0 1 00000056 00000000 0 00000000
00000140 09 0a 00000011 00000022 00000000 0 0 00 1 0 0 1 00000033 00000022 0 00000000
00000144 00 00 00000000 00000000 00000000 0 0 0b 1 0 0 1 00000000 00000000 0 00000000
00000148 0b 0c 00000999 cafef00d 00000008 0 1 00 3 0 0 1 00000008 cafef00d 0 00000000
0000014c 01 02 00000007 00000007 00000040 1 1 00 4 1 0 1 0000018c 00000007 1 0000018c
00000150 03 04 00000001 00000001 00000000 0 0 05 1 0 0 0 00000000 00000000 0 00000000
0000018c 01 02 00000007 00000007 00000020 1 1 00 4 2 0 1 000001ac 00000007 0 00000000
00000190 01 02 00000007 00000008 fffffff0 1 1 00 4 2 0 1 00000180 00000008 1 00000180
00000194 03 00 00000200 00000000 00000000 0 1 01 5 0 0 0 00000000 00000000 0 00000000
00000180 01 02 00000005 fffffffb 00000010 1 1 00 4 3 0 1 00000190 fffffffb 0 00000000
00000184 01 02 fffffffb 00000005 00000100 1 1 00 4 3 0 1 00000284 00000005 1 00000284
00000188 03 04 00000001 00000001 00000000 0 0 05 1 0 0 0 00000000 00000000 0 00000000
00000284 01 02 fffffffb 00000005 00000008 1 1 00 4 4 0 1 0000028c 00000005 0 00000000
00000288 01 02 00000005 00000005 00000020 1 1 00 4 4 0 1 000002a8 00000005 1 000002a8
0000028c 03 04 00000001 00000001 00000000 0 0 05 1 0 0 0 00000000 00000000 0 00000000
000002a8 01 02 fffffffb 00000005 00000004 1 1 00 4 5 0 1 000002ac 00000005 0 00000000
000002ac 01 02 00000005 fffffffb 00000054 1 1 00 4 5 0 1 00000300 fffffffb 1 00000300
000002b0 03 04 00000001 00000001 00000000 0 0 05 1 0 0 0 00000000 00000000 0 00000000
00000300 01 02 00000005 fffffffb 00000008 1 1 00 4 6 0 1 00000308 fffffffb 0 00000000
00000304 01 02 fffffffb 00000005 000000fc 1 1 00 4 6 0 1 00000400 00000005 1 00000400
00000308 03 04 00000001 00000001 00000000 0 0 05 1 0 0 0 00000000 00000000 0 00000000
00000400 01 02 00000001 00000002 00000008 1 1 00 4 1 0 1 00000408 00000002 0 00000000
00000404 0d 00 00000800 00000000 00000010 0 1 01 5 0 0 1 00000408 00000000 1 00000810
00000408 03 04 00000001 00000001 00000000 0 0 05 1 0 0 0 00000000 00000000 0 00000000
00000810 01 00 00000010 00000000 00000004 0 1 02 1 0 0 1 00000014 00000000 0 00000000
00000814 00 00 00000000 00000000 00000000 0 0 00 0 0 0 0 00000000 00000000 0 00000000
00000818 02 00 00000001 00000000 00000001 0 1 03 1 0 0 1 00000002 00000000 0 00000000

/* all.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
alu.sv
forward_unit.sv
execute.sv
redirect_ctrl.sv
ex_top.sv
tb_ex_top.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP   = tb_ex_top
FLIST = all.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_ex_top.sv */
// Golden file testbench; run from the project root so ex_golden.hex is found, 64 records at most
`timescale 1ns/1ps

module tb_ex_top;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int REC_W     = 17;  // words per golden record
    localparam int MAX_REC   = 64;
    localparam int HALF_CLK  = 4;
    localparam int REC_LIMIT = 40;  // watchdog cycles per record

    logic     sink;
    logic     rst_n;
    logic     ex_valid;
    logic     ex_ready;
    word_t    ex_pc;
    reg_idx_t ex_rs1_idx;
    reg_idx_t ex_rs2_idx;
    word_t    ex_rs1;
    word_t    ex_rs2;
    word_t    ex_imm;
    logic     ex_op1_pc;
    logic     ex_op2_imm;
    reg_idx_t ex_rd;
    op_t      ex_op;
    br_t      ex_br;
    alu_fun_t ex_fun;
    logic     mm_valid;
    logic     mm_ready;
    op_t      mm_op;
    reg_idx_t mm_rd;
    word_t    mm_result;
    word_t    mm_store_data;
    logic     redirect_valid;
    logic     redirect_ready;
    word_t    redirect_target;

    word_t    gold [0:MAX_REC*REC_W];  // word 0 is the record count
    int       n_rec = 0;
    int       cur_rec = 0;
    int       mm_q[$];
    int       rd_q[$];
    logic     redirect_due = 1'b0;  // taken record sent, handshake not yet seen
    logic     mm_held = 1'b0;
    logic     rd_held = 1'b0;
    op_t      held_op;
    reg_idx_t held_rd;
    word_t    held_result;
    word_t    held_store;
    word_t    held_target;

    ex_top i_dut (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_golden();
        int base;
        $readmemh("ex_golden.hex", gold);
        n_rec = int'(gold[0]);
        if (n_rec <= 0 || n_rec > MAX_REC) begin
            abort_run("golden file missing or its record count is out of range");
        end else begin
            for (int i = 0; i < n_rec; i++) begin
                base = 1 + i * REC_W;
                if (gold[base + 12][0])
                    mm_q.push_back(i);
                if (gold[base + 15][0])
                    rd_q.push_back(i);
            end
        end
    endtask

    task automatic drive_record(input int idx);
        int b;
        b = 1 + idx * REC_W;
        cur_rec    = idx;
        ex_valid   <= 1'b1;
        ex_pc      <= gold[b];
        ex_rs1_idx <= gold[b + 1][4:0];
        ex_rs2_idx <= gold[b + 2][4:0];
        ex_rs1     <= gold[b + 3];
        ex_rs2     <= gold[b + 4];
        ex_imm     <= gold[b + 5];
        ex_op1_pc  <= gold[b + 6][0];
        ex_op2_imm <= gold[b + 7][0];
        ex_rd      <= gold[b + 8][4:0];
        ex_op      <= op_t'(gold[b + 9][2:0]);
        ex_br      <= br_t'(gold[b + 10][2:0]);
        ex_fun     <= alu_fun_t'(gold[b + 11][3:0]);
    endtask

    // transfer happens on the posedge after a ready negedge
    task automatic wait_accept();
        do
            @(negedge sink);
        while (!ex_ready);
    endtask

    task automatic collect_mm();
        int b;
        if (mm_q.size() == 0) begin
            abort_run("mm record appeared after all expected records were seen");
        end else begin
            b = 1 + mm_q.pop_front() * REC_W;
            compare_word("mm_op", word_t'(mm_op), gold[b + 9]);
            compare_word("mm_rd", word_t'(mm_rd), gold[b + 8]);
            compare_word("mm_result", mm_result, gold[b + 13]);
            compare_word("mm_store_data", mm_store_data, gold[b + 14]);
        end
    endtask

    task automatic collect_redirect();
        int b;
        if (rd_q.size() == 0) begin
            abort_run("redirect raised where no taken branch or jump was expected");
        end else begin
            b = 1 + rd_q.pop_front() * REC_W;
            compare_word("redirect_target", redirect_target, gold[b + 16]);
        end
    endtask

    // input is blocked from a taken transfer until fetch takes the redirect
    task automatic track_redirect();
        if (redirect_valid && redirect_ready)
            redirect_due = 1'b0;
        if (ex_valid && ex_ready && gold[1 + cur_rec * REC_W + 15][0])
            redirect_due = 1'b1;
    endtask

    task automatic check_hold();
        if (mm_held) begin
            compare_word("mm_valid", word_t'(mm_valid), 32'd1);
            compare_word("mm_op", word_t'(mm_op), word_t'(held_op));
            compare_word("mm_rd", word_t'(mm_rd), word_t'(held_rd));
            compare_word("mm_result", mm_result, held_result);
            compare_word("mm_store_data", mm_store_data, held_store);
        end
        if (rd_held) begin
            compare_word("redirect_valid", word_t'(redirect_valid), 32'd1);
            compare_word("redirect_target", redirect_target, held_target);
        end
    endtask

    task automatic capture_hold();
        mm_held     = mm_valid && !mm_ready;
        rd_held     = redirect_valid && !redirect_ready;
        held_op     = mm_op;
        held_rd     = mm_rd;
        held_result = mm_result;
        held_store  = mm_store_data;
        held_target = redirect_target;
    endtask

    initial begin
        sink = 1'b0;
        forever #HALF_CLK sink = ~sink;
    end

    // random back-pressure on both ready inputs
    initial begin
        void'($urandom(73));
        mm_ready       = 1'b0;
        redirect_ready = 1'b0;
        @(posedge rst_n);
        forever begin
            @(posedge sink);
            mm_ready       <= ($urandom % 4) != 0;
            redirect_ready <= ($urandom % 3) != 0;
        end
    end

    // outputs are sampled on the falling edge
    always @(negedge sink) begin
        if (rst_n) begin
            check_hold();
            compare_word("ex_ready", word_t'(ex_ready), word_t'(mm_ready && !redirect_due));
            if (mm_valid && mm_ready)
                collect_mm();
            if (redirect_valid && redirect_ready)
                collect_redirect();
            track_redirect();
            capture_hold();
        end
    end

    initial begin
        wait (n_rec > 0);
        repeat (n_rec * REC_LIMIT + 8) @(posedge sink);
        abort_run("timeout: the DUT stopped making progress before all records were done");
    end

    initial begin
        rst_n      = 1'b0;
        ex_valid   = 1'b0;
        ex_pc      = '0;
        ex_rs1_idx = '0;
        ex_rs2_idx = '0;
        ex_rs1     = '0;
        ex_rs2     = '0;
        ex_imm     = '0;
        ex_op1_pc  = 1'b0;
        ex_op2_imm = 1'b0;
        ex_rd      = '0;
        ex_op      = NONE;
        ex_br      = IGNORE;
        ex_fun     = ADD;
        load_golden();
        repeat (4) @(posedge sink);
        rst_n <= 1'b1;
        for (int i = 0; i < n_rec; i++) begin
            @(posedge sink);
            drive_record(i);
            wait_accept();
        end
        @(posedge sink);
        ex_valid <= 1'b0;
        for (int w = 0; w < 200 && (mm_q.size() != 0 || rd_q.size() != 0); w++)
            @(posedge sink);
        repeat (8) @(posedge sink);  // room for stray records
        if (mm_q.size() == 0 && rd_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("some expected mm records or redirects never appeared");
        end
    end

endmodule

/* ex_top.sv */
// Execute subsystem top; upstream must stall load-use pairs since LOAD results are not bypassed
`timescale 1ns/1ps

module ex_top (
    input  logic                sink,
    input  logic                rst_n,
    input  logic                ex_valid,
    output logic                ex_ready,
    input  isa_pkg::word_t      ex_pc,
    input  pipe_pkg::reg_idx_t  ex_rs1_idx,
    input  pipe_pkg::reg_idx_t  ex_rs2_idx,
    input  isa_pkg::word_t      ex_rs1,
    input  isa_pkg::word_t      ex_rs2,
    input  isa_pkg::word_t      ex_imm,
    input  logic                ex_op1_pc,
    input  logic                ex_op2_imm,
    input  pipe_pkg::reg_idx_t  ex_rd,
    input  isa_pkg::op_t        ex_op,
    input  isa_pkg::br_t        ex_br,
    input  isa_pkg::alu_fun_t   ex_fun,
    output logic                mm_valid,
    input  logic                mm_ready,
    output isa_pkg::op_t        mm_op,
    output pipe_pkg::reg_idx_t  mm_rd,
    output isa_pkg::word_t      mm_result,
    output isa_pkg::word_t      mm_store_data,
    output logic                redirect_valid,
    input  logic                redirect_ready,
    output isa_pkg::word_t      redirect_target
);
    import isa_pkg::*;

    word_t rs1;
    word_t rs2;
    word_t op1;
    word_t op2;
    word_t target;
    logic  taken;
    logic  accept_en;
    logic  squash;
    logic  accept;

    assign ex_ready = mm_ready && accept_en;
    assign accept   = ex_valid && ex_ready;

    forward_unit i_forward_unit (
        .ex_pc      (ex_pc),
        .ex_rs1     (ex_rs1),
        .ex_rs2     (ex_rs2),
        .ex_imm     (ex_imm),
        .ex_rs1_idx (ex_rs1_idx),
        .ex_rs2_idx (ex_rs2_idx),
        .ex_op1_pc  (ex_op1_pc),
        .ex_op2_imm (ex_op2_imm),
        .mm_valid   (mm_valid),
        .mm_op      (mm_op),
        .mm_rd      (mm_rd),
        .mm_result  (mm_result),
        .rs1        (rs1),
        .rs2        (rs2),
        .op1        (op1),
        .op2        (op2)
    );

    execute i_execute (
        .sink          (sink),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .accept        (accept),
        .squash        (squash),
        .ex_pc         (ex_pc),
        .rs1           (rs1),
        .rs2           (rs2),
        .op1           (op1),
        .op2           (op2),
        .ex_imm        (ex_imm),
        .ex_rd         (ex_rd),
        .ex_op         (ex_op),
        .ex_br         (ex_br),
        .ex_fun        (ex_fun),
        .mm_ready      (mm_ready),
        .taken         (taken),
        .target        (target),
        .mm_valid      (mm_valid),
        .mm_op         (mm_op),
        .mm_rd         (mm_rd),
        .mm_result     (mm_result),
        .mm_store_data (mm_store_data)
    );

    redirect_ctrl i_redirect_ctrl (
        .sink            (sink),
        .rst_n           (rst_n),
        .ex_valid        (ex_valid),
        .mm_ready        (mm_ready),
        .taken           (taken),
        .target          (target),
        .redirect_ready  (redirect_ready),
        .accept_en       (accept_en),
        .squash          (squash),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target)
    );

endmodule

/* redirect_ctrl.sv */
// Redirect FSM for one taken branch at a time; exactly one wrong-path instruction is squashed
`timescale 1ns/1ps

module redirect_ctrl (
    input  logic           sink,
    input  logic           rst_n,
    input  logic           ex_valid,
    input  logic           mm_ready,
    input  logic           taken,
    input  isa_pkg::word_t target,
    input  logic           redirect_ready,
    output logic           accept_en,
    output logic           squash,
    output logic           redirect_valid,
    output isa_pkg::word_t redirect_target
);
    import pipe_pkg::*;

    redirect_state_t state;
    redirect_state_t state_nxt;
    logic            accepted;
    logic            start;

    assign accept_en      = (state != REQUEST);  // hold decode while fetch turns around
    assign squash         = (state == SQUASH);
    assign redirect_valid = (state == REQUEST);

    // mirrors the input handshake formed in ex_top
    assign accepted = ex_valid && mm_ready && accept_en;
    assign start    = (state == IDLE) && accepted && taken;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = REQUEST;
            REQUEST: if (redirect_ready) state_nxt = SQUASH;
            SQUASH:  if (accepted) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge sink or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge sink) begin
        if (start)
            redirect_target <= target;
    end

    a_target_hold: assert property (@(posedge sink) disable iff (!rst_n)
        redirect_valid && !redirect_ready |=> redirect_valid && $stable(redirect_target))
        else $error("redirect target changed before handshake");

    // a killed instruction must never start a redirect
    a_squash_no_redirect: assert property (@(posedge sink) disable iff (!rst_n)
        squash && accepted |=> !redirect_valid)
        else $error("redirect raised by squashed instruction");

endmodule

/* execute.sv */
// Execute stage with one registered mm record; misaligned targets and exceptions are not checked
`timescale 1ns/1ps

module execute (
    input  logic                sink,
    input  logic                rst_n,
    input  logic                ex_valid,
    input  logic                accept,
    input  logic                squash,
    input  isa_pkg::word_t      ex_pc,
    input  isa_pkg::word_t      rs1,
    input  isa_pkg::word_t      rs2,
    input  isa_pkg::word_t      op1,
    input  isa_pkg::word_t      op2,
    input  isa_pkg::word_t      ex_imm,
    input  pipe_pkg::reg_idx_t  ex_rd,
    input  isa_pkg::op_t        ex_op,
    input  isa_pkg::br_t        ex_br,
    input  isa_pkg::alu_fun_t   ex_fun,
    input  logic                mm_ready,
    output logic                taken,
    output isa_pkg::word_t      target,
    output logic                mm_valid,
    output isa_pkg::op_t        mm_op,
    output pipe_pkg::reg_idx_t  mm_rd,
    output isa_pkg::word_t      mm_result,
    output isa_pkg::word_t      mm_store_data
);
    import isa_pkg::*;

    word_t alu_out;
    word_t link;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  cond;
    logic  load;

    alu i_alu (
        .fun (ex_fun),
        .op1 (op1),
        .op2 (op2),
        .out (alu_out)
    );

    assign eq  = rs1 == rs2;
    assign lt  = $signed(rs1) < $signed(rs2);
    assign ltu = rs1 < rs2;

    always_comb begin
        case (ex_br)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt;
            BGE:     cond = !lt;
            BLTU:    cond = ltu;
            BGEU:    cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign taken  = ex_valid && (ex_op == JUMP || (ex_op == BRANCH && cond));
    assign target = (ex_op == JUMP) ? rs1 + ex_imm : ex_pc + ex_imm;
    assign link   = ex_pc + word_t'(4);

    // squashed and NONE slots leave a bubble
    assign load = accept && !squash && (ex_op != NONE);

    always_ff @(posedge sink or negedge rst_n) begin
        if (!rst_n) begin
            mm_valid <= 1'b0;
            mm_op    <= NONE;
            mm_rd    <= '0;
        end else if (mm_ready) begin
            mm_valid <= load;
            mm_op    <= load ? ex_op : NONE;
            if (load)
                mm_rd <= ex_rd;
        end
    end

    always_ff @(posedge sink) begin
        if (mm_ready && load) begin
            mm_result     <= (ex_op == JUMP) ? link : alu_out;
            mm_store_data <= rs2;
        end
    end

    // downstream sees a frozen record until it takes it
    a_mm_hold: assert property (@(posedge sink) disable iff (!rst_n)
        mm_valid && !mm_ready |=>
            mm_valid && $stable({mm_op, mm_rd, mm_result, mm_store_data}))
        else $error("mm record changed under back-pressure");

endmodule

/* forward_unit.sv */
// Operand bypass from the one-deep memory-stage record; LOAD results are never forwarded
`timescale 1ns/1ps

module forward_unit (
    input  isa_pkg::word_t    ex_pc,
    input  isa_pkg::word_t    ex_rs1,
    input  isa_pkg::word_t    ex_rs2,
    input  isa_pkg::word_t    ex_imm,
    input  pipe_pkg::reg_idx_t ex_rs1_idx,
    input  pipe_pkg::reg_idx_t ex_rs2_idx,
    input  logic              ex_op1_pc,
    input  logic              ex_op2_imm,
    input  logic              mm_valid,
    input  isa_pkg::op_t      mm_op,
    input  pipe_pkg::reg_idx_t mm_rd,
    input  isa_pkg::word_t    mm_result,
    output isa_pkg::word_t    rs1,
    output isa_pkg::word_t    rs2,
    output isa_pkg::word_t    op1,
    output isa_pkg::word_t    op2
);
    import isa_pkg::*;

    logic mm_writes;
    logic hit_rs1;
    logic hit_rs2;

    // only ALU and JUMP results are ready in the mm record
    assign mm_writes = mm_valid && (mm_op == ALU || mm_op == JUMP) && (mm_rd != '0);

    assign hit_rs1 = mm_writes && (mm_rd == ex_rs1_idx);
    assign hit_rs2 = mm_writes && (mm_rd == ex_rs2_idx);

    assign rs1 = hit_rs1 ? mm_result : ex_rs1;
    assign rs2 = hit_rs2 ? mm_result : ex_rs2;

    assign op1 = ex_op1_pc  ? ex_pc  : rs1;  // auipc, branch and jal use pc
    assign op2 = ex_op2_imm ? ex_imm : rs2;

endmodule

/* alu.sv */
// Combinational RV32I integer ALU; shift amount is taken from the low SHAMT_W bits of op2
`timescale 1ns/1ps

`include "core_cfg.svh"

module alu (
    input  isa_pkg::alu_fun_t fun,
    input  isa_pkg::word_t    op1,
    input  isa_pkg::word_t    op2,
    output isa_pkg::word_t    out
);
    import isa_pkg::*;

    logic [`SHAMT_W-1:0] shamt;
    logic                lt;
    logic                ltu;

    assign shamt = op2[`SHAMT_W-1:0];
    assign lt    = $signed(op1) < $signed(op2);
    assign ltu   = op1 < op2;

    always_comb begin
        case (fun)
            ADD:     out = op1 + op2;
            SUB:     out = op1 - op2;
            SLL:     out = op1 << shamt;
            SLT:     out = word_t'(lt);     // zero extended flag
            SLTU:    out = word_t'(ltu);
            XOR:     out = op1 ^ op2;
            SRL:     out = op1 >> shamt;
            SRA:     out = word_t'($signed(op1) >>> shamt);
            OR:      out = op1 | op2;
            AND:     out = op1 & op2;
            PASS_B:  out = op2;
            default: out = '0;
        endcase
    end

endmodule

/* pipe_pkg.sv */
// Pipeline control types for the execute block; register index width comes from core_cfg.svh
package pipe_pkg;

`include "core_cfg.svh"

    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // redirect controller states
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        SQUASH
    } redirect_state_t;

endpackage

/* isa_pkg.sv */
// Instruction level types for the execute block; enum encodings are fixed and shared with decode
package isa_pkg;

`include "core_cfg.svh"

    typedef logic [`XLEN-1:0] word_t;

    // operation class from decode
    typedef enum logic [2:0] {
        NONE,
        ALU,
        LOAD,
        STORE,
        BRANCH,
        JUMP
    } op_t;

    typedef enum logic [2:0] {
        IGNORE,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } br_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B  // lui style immediate
    } alu_fun_t;

endpackage

/* core_cfg.svh */
// Core width settings shared by both packages and the ALU; only XLEN of 32 is supported
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data path width in bits
`define XLEN 32

// register index width for 32 architectural registers
`define REG_IDX_W 5

// shift amount width for an XLEN of 32
`define SHAMT_W 5

`endif
